/* Makefile */
# Verilator build and run of the memory stage testbench.

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f src.f --top-module mem_stage_tb \
		-Mdir obj_dir -o mem_stage_tb
	./obj_dir/mem_stage_tb | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* hdl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  aluop_t;
    typedef logic [7:0]  except_t;

    // bit positions inside except_t.
    localparam int unsigned EXC_ADEL = 0;
    localparam int unsigned EXC_ADES = 1;
    localparam int unsigned EXC_SYS  = 2; // set by fetch, decode or execute.

    localparam aluop_t ALUOP_LB  = 8'h80;
    localparam aluop_t ALUOP_LBU = 8'h81;
    localparam aluop_t ALUOP_LH  = 8'h82;
    localparam aluop_t ALUOP_LHU = 8'h83;
    localparam aluop_t ALUOP_LW  = 8'h84;
    localparam aluop_t ALUOP_SB  = 8'h88;
    localparam aluop_t ALUOP_SH  = 8'h89;
    localparam aluop_t ALUOP_SW  = 8'h8a;

    localparam int unsigned RAM_AW = 8; // word address bits decoded by the data RAM.

    typedef struct packed {
        logic        mem_en;
        logic        hilo_wen;
        logic        memtoreg;
        logic        reg_wen;
        logic        cp0_wen;
        logic        in_delayslot;
        reg_addr_t   reg_waddr;
        reg_addr_t   rd;
        aluop_t      aluop;
        except_t     except;
        word_t       rt_value;
        word_t       alu_res;
        word_t       pc;
        word_t       mem_addr;
        logic [63:0] alu_out64;
    } master_ex_t;

    // the slave lane never touches memory or HI/LO.
    typedef struct packed {
        logic      reg_wen;
        logic      memtoreg;
        logic      cp0_wen;
        logic      in_delayslot;
        reg_addr_t reg_waddr;
        aluop_t    aluop;
        except_t   except;
        word_t     pc;
        word_t     alu_res;
    } slave_ex_t;

    typedef struct packed {
        logic        reg_wen;
        reg_addr_t   reg_waddr;
        word_t       reg_wdata;
        logic        hilo_wen;
        logic [63:0] hilo_data;
        logic        cp0_wen;
        reg_addr_t   cp0_addr;
        word_t       cp0_data;
        except_t     except;
        word_t       pc;
        logic        in_delayslot;
    } commit_t;

endpackage

`default_nettype wire

/* hdl/data_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module data_ram (
    input  wire logic           clk,
    input  wire cpu_pkg::word_t addr,
    input  wire cpu_pkg::word_t wdata,
    input  wire logic [3:0]     be,
    input  wire logic           we,
    output cpu_pkg::word_t      rdata
);

    cpu_pkg::word_t             mem [2**cpu_pkg::RAM_AW];
    logic [cpu_pkg::RAM_AW-1:0] widx;

    // upper address bits alias onto the same words.
    assign widx = addr[cpu_pkg::RAM_AW+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[widx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    assign rdata = mem[widx]; // the read is asynchronous so the load completes in M.

endmodule

`default_nettype wire

/* hdl/ex_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_mem (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                clear_master,
    input  wire logic                clear_slave,
    input  wire logic                ena_master,
    input  wire logic                ena_slave,
    input  wire cpu_pkg::master_ex_t e_master,
    input  wire cpu_pkg::slave_ex_t  e_slave,
    output cpu_pkg::master_ex_t      m_master,
    output cpu_pkg::slave_ex_t       m_slave
);

    // the master lane holds the older instruction of the pair.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_master <= '0;
        end else if (clear_master) begin
            m_master <= '0; // a cleared lane is a bubble.
        end else if (ena_master) begin
            m_master <= e_master;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_slave <= '0;
        end else if (clear_slave) begin
            m_slave <= '0;
        end else if (ena_slave) begin
            m_slave <= e_slave;
        end
    end

    // clear must win over a simultaneous enable.
    master_clear_zeroes: assert property (
        @(posedge clk) disable iff (!arst_n)
        clear_master |=> (m_master == '0)
    ) else $error("master lane not zero after clear.");

endmodule

`default_nettype wire

/* hdl/issue_flush_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_flush_ctrl (
    input  wire logic             stall_m,
    input  wire logic             flush,
    input  wire cpu_pkg::except_t e_master_except,
    output logic                  clear_master,
    output logic                  clear_slave,
    output logic                  ena_master,
    output logic                  ena_slave
);

    logic master_excepts;

    assign master_excepts = |e_master_except;

    assign clear_master = flush;

    // a slave issued beside an excepting master is younger and must die.
    // under stall the pair holds, so the kill waits for the master to move.
    assign clear_slave = flush | (master_excepts & ~stall_m);

    assign ena_master = ~stall_m;
    assign ena_slave  = ~stall_m;

    always_comb begin
        assert (!clear_master || clear_slave)
            else $error("master lane cleared while slave lane kept.");
    end

endmodule

`default_nettype wire

/* hdl/mem_commit.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_commit (
    input  wire cpu_pkg::master_ex_t m_master,
    input  wire cpu_pkg::slave_ex_t  m_slave,
    input  wire cpu_pkg::word_t      ram_rdata,
    output cpu_pkg::word_t           ram_addr,
    output cpu_pkg::word_t           ram_wdata,
    output logic [3:0]               ram_be,
    output logic                     ram_we,
    output cpu_pkg::commit_t         m_master_commit,
    output cpu_pkg::commit_t         m_slave_commit
);

    logic             is_load;
    logic             is_store;
    logic             is_byte;
    logic             is_half;
    logic             is_word;
    logic             sign_ext;
    logic [1:0]       off;
    logic             misaligned;
    logic             master_kill;
    logic             slave_kill;
    logic [7:0]       load_byte;
    logic [15:0]      load_half;
    cpu_pkg::word_t   load_data;
    cpu_pkg::except_t master_exc;

    assign off = m_master.mem_addr[1:0];

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_byte  = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        sign_ext = 1'b0;
        if (m_master.mem_en) begin
            case (m_master.aluop)
                cpu_pkg::ALUOP_LB: begin
                    is_load  = 1'b1;
                    is_byte  = 1'b1;
                    sign_ext = 1'b1;
                end
                cpu_pkg::ALUOP_LBU: begin
                    is_load = 1'b1;
                    is_byte = 1'b1;
                end
                cpu_pkg::ALUOP_LH: begin
                    is_load  = 1'b1;
                    is_half  = 1'b1;
                    sign_ext = 1'b1;
                end
                cpu_pkg::ALUOP_LHU: begin
                    is_load = 1'b1;
                    is_half = 1'b1;
                end
                cpu_pkg::ALUOP_LW: begin
                    is_load = 1'b1;
                    is_word = 1'b1;
                end
                cpu_pkg::ALUOP_SB: begin
                    is_store = 1'b1;
                    is_byte  = 1'b1;
                end
                cpu_pkg::ALUOP_SH: begin
                    is_store = 1'b1;
                    is_half  = 1'b1;
                end
                cpu_pkg::ALUOP_SW: begin
                    is_store = 1'b1;
                    is_word  = 1'b1;
                end
                default: ; // unknown op with mem_en set makes no access.
            endcase
        end
    end

    assign misaligned = (is_half & off[0]) | (is_word & (off != 2'b00));

    always_comb begin
        master_exc = m_master.except;
        master_exc[cpu_pkg::EXC_ADEL] = master_exc[cpu_pkg::EXC_ADEL] | (is_load & misaligned);
        master_exc[cpu_pkg::EXC_ADES] = master_exc[cpu_pkg::EXC_ADES] | (is_store & misaligned);
    end

    assign master_kill = |master_exc;
    assign slave_kill  = master_kill | (|m_slave.except); // the slave is younger.

    // stores replicate the data so every addressed lane sees its bytes.
    assign ram_addr  = m_master.mem_addr;
    assign ram_wdata = is_byte ? {4{m_master.rt_value[7:0]}} :
                       is_half ? {2{m_master.rt_value[15:0]}} : m_master.rt_value;
    assign ram_be    = !is_store ? 4'b0000 :
                       is_byte   ? (4'b0001 << off) :
                       is_half   ? (off[1] ? 4'b1100 : 4'b0011) : 4'b1111;
    assign ram_we    = is_store & ~master_kill;

    assign load_byte = ram_rdata[8*off +: 8];
    assign load_half = off[1] ? ram_rdata[31:16] : ram_rdata[15:0];
    assign load_data = is_byte ? {{24{sign_ext & load_byte[7]}}, load_byte} :
                       is_half ? {{16{sign_ext & load_half[15]}}, load_half} : ram_rdata;

    always_comb begin
        m_master_commit.reg_wen      = m_master.reg_wen & ~master_kill;
        m_master_commit.reg_waddr    = m_master.reg_waddr;
        m_master_commit.reg_wdata    = (is_load & m_master.memtoreg) ? load_data
                                                                     : m_master.alu_res;
        m_master_commit.hilo_wen     = m_master.hilo_wen & ~master_kill;
        m_master_commit.hilo_data    = m_master.alu_out64;
        m_master_commit.cp0_wen      = m_master.cp0_wen & ~master_kill;
        m_master_commit.cp0_addr     = m_master.rd;
        m_master_commit.cp0_data     = m_master.rt_value; // mtc0 moves rt into CP0.
        m_master_commit.except       = master_exc;
        m_master_commit.pc           = m_master.pc;
        m_master_commit.in_delayslot = m_master.in_delayslot;
    end

    // the slave has no rd field, so its CP0 target travels in reg_waddr.
    always_comb begin
        m_slave_commit.reg_wen      = m_slave.reg_wen & ~slave_kill;
        m_slave_commit.reg_waddr    = m_slave.reg_waddr;
        m_slave_commit.reg_wdata    = m_slave.alu_res;
        m_slave_commit.hilo_wen     = 1'b0;
        m_slave_commit.hilo_data    = '0;
        m_slave_commit.cp0_wen      = m_slave.cp0_wen & ~slave_kill;
        m_slave_commit.cp0_addr     = m_slave.reg_waddr;
        m_slave_commit.cp0_data     = m_slave.alu_res;
        m_slave_commit.except       = m_slave.except;
        m_slave_commit.pc           = m_slave.pc;
        m_slave_commit.in_delayslot = m_slave.in_delayslot;
    end

    always_comb begin
        if (ram_we) begin
            assert (m_master_commit.except == '0)
                else $error("RAM write issued for an excepting master.");
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                stall_m,
    input  wire logic                flush,
    input  wire cpu_pkg::master_ex_t e_master,
    input  wire cpu_pkg::slave_ex_t  e_slave,
    output cpu_pkg::commit_t         m_master_commit,
    output cpu_pkg::commit_t         m_slave_commit
);

    logic                clear_master;
    logic                clear_slave;
    logic                ena_master;
    logic                ena_slave;
    cpu_pkg::master_ex_t m_master;
    cpu_pkg::slave_ex_t  m_slave;
    cpu_pkg::word_t      ram_addr;
    cpu_pkg::word_t      ram_wdata;
    cpu_pkg::word_t      ram_rdata;
    logic [3:0]          ram_be;
    logic                ram_we;

    issue_flush_ctrl u_issue_flush_ctrl (
        .stall_m         (stall_m),
        .flush           (flush),
        .e_master_except (e_master.except),
        .clear_master    (clear_master),
        .clear_slave     (clear_slave),
        .ena_master      (ena_master),
        .ena_slave       (ena_slave)
    );

    ex_mem u_ex_mem (
        .clk          (clk),
        .arst_n       (arst_n),
        .clear_master (clear_master),
        .clear_slave  (clear_slave),
        .ena_master   (ena_master),
        .ena_slave    (ena_slave),
        .e_master     (e_master),
        .e_slave      (e_slave),
        .m_master     (m_master),
        .m_slave      (m_slave)
    );

    mem_commit u_mem_commit (
        .m_master        (m_master),
        .m_slave         (m_slave),
        .ram_rdata       (ram_rdata),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata),
        .ram_be          (ram_be),
        .ram_we          (ram_we),
        .m_master_commit (m_master_commit),
        .m_slave_commit  (m_slave_commit)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .be    (ram_be),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

/* sim/mem_stage_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage_tb;

    localparam int          RANDOM_CYCLES = 2000;
    localparam int          MAX_CYCLES    = 3000; // tests need about 2,300 cycles.
    localparam logic [31:0] SEED          = 32'he899_8e4f;

    logic                clk;
    logic                arst_n;
    logic                stall_m;
    logic                flush;
    cpu_pkg::master_ex_t e_master;
    cpu_pkg::slave_ex_t  e_slave;
    cpu_pkg::commit_t    m_master_commit;
    cpu_pkg::commit_t    m_slave_commit;

    cpu_pkg::master_ex_t mdl_master;
    cpu_pkg::slave_ex_t  mdl_slave;
    cpu_pkg::word_t      mdl_mem [2**cpu_pkg::RAM_AW];
    cpu_pkg::commit_t    last_master;
    cpu_pkg::commit_t    last_slave;
    int                  checks;
    int                  errors;
    int                  cycles = 0;

    tb_clock u_tb_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .arst_n          (arst_n),
        .stall_m         (stall_m),
        .flush           (flush),
        .e_master        (e_master),
        .e_slave         (e_slave),
        .m_master_commit (m_master_commit),
        .m_slave_commit  (m_slave_commit)
    );

    function automatic int op_size(input cpu_pkg::aluop_t op);
        case (op)
            cpu_pkg::ALUOP_LB, cpu_pkg::ALUOP_LBU, cpu_pkg::ALUOP_SB: return 1;
            cpu_pkg::ALUOP_LH, cpu_pkg::ALUOP_LHU, cpu_pkg::ALUOP_SH: return 2;
            cpu_pkg::ALUOP_LW, cpu_pkg::ALUOP_SW: return 4;
            default: return 0;
        endcase
    endfunction

    function automatic bit is_store_op(input cpu_pkg::aluop_t op);
        return op == cpu_pkg::ALUOP_SB || op == cpu_pkg::ALUOP_SH || op == cpu_pkg::ALUOP_SW;
    endfunction

    function automatic bit is_signed_op(input cpu_pkg::aluop_t op);
        return op == cpu_pkg::ALUOP_LB || op == cpu_pkg::ALUOP_LH;
    endfunction

    function automatic cpu_pkg::except_t expected_master_except(input cpu_pkg::master_ex_t m);
        cpu_pkg::except_t exc;
        int               sz;
        exc = m.except;
        sz  = m.mem_en ? op_size(m.aluop) : 0;
        if (sz != 0 && int'(m.mem_addr[1:0]) % sz != 0) begin
            if (is_store_op(m.aluop)) begin
                exc[cpu_pkg::EXC_ADES] = 1'b1;
            end else begin
                exc[cpu_pkg::EXC_ADEL] = 1'b1;
            end
        end
        return exc;
    endfunction

    function automatic cpu_pkg::commit_t expected_master(input cpu_pkg::master_ex_t m);
        cpu_pkg::commit_t c;
        cpu_pkg::word_t   w;
        int               sz;
        int               boff;
        logic             kill;
        c         = '0;
        c.except  = expected_master_except(m);
        kill      = (c.except != '0);
        sz        = m.mem_en ? op_size(m.aluop) : 0;
        c.reg_wen   = m.reg_wen && !kill;
        c.reg_waddr = m.reg_waddr;
        c.reg_wdata = m.alu_res;
        if (sz != 0 && !is_store_op(m.aluop) && m.memtoreg) begin
            // the naturally aligned unit that holds the address is read.
            boff = int'(m.mem_addr[1:0]) - int'(m.mem_addr[1:0]) % sz;
            w    = mdl_mem[m.mem_addr[cpu_pkg::RAM_AW+1:2]] >> (8 * boff);
            case (sz)
                1: c.reg_wdata = is_signed_op(m.aluop) ? {{24{w[7]}}, w[7:0]} : {24'd0, w[7:0]};
                2: c.reg_wdata = is_signed_op(m.aluop) ? {{16{w[15]}}, w[15:0]}
                                                       : {16'd0, w[15:0]};
                default: c.reg_wdata = w;
            endcase
        end
        c.hilo_wen     = m.hilo_wen && !kill;
        c.hilo_data    = m.alu_out64;
        c.cp0_wen      = m.cp0_wen && !kill;
        c.cp0_addr     = m.rd;
        c.cp0_data     = m.rt_value;
        c.pc           = m.pc;
        c.in_delayslot = m.in_delayslot;
        return c;
    endfunction

    function automatic cpu_pkg::commit_t expected_slave(input cpu_pkg::slave_ex_t s,
                                                        input logic master_kill);
        cpu_pkg::commit_t c;
        logic             kill;
        c              = '0;
        kill           = master_kill || s.except != '0; // the slave is younger.
        c.reg_wen      = s.reg_wen && !kill;
        c.reg_waddr    = s.reg_waddr;
        c.reg_wdata    = s.alu_res;
        c.cp0_wen      = s.cp0_wen && !kill;
        c.cp0_addr     = s.reg_waddr;
        c.cp0_data     = s.alu_res;
        c.except       = s.except;
        c.pc           = s.pc;
        c.in_delayslot = s.in_delayslot;
        return c;
    endfunction

    function automatic bit writes_off(input cpu_pkg::commit_t c);
        return !c.reg_wen && !c.hilo_wen && !c.cp0_wen;
    endfunction

    function automatic logic [319:0] random_bits();
        logic [319:0] v;
        for (int i = 0; i < 10; i++) begin
            v[32*i +: 32] = $urandom;
        end
        return v;
    endfunction

    // kind 0 is ALU traffic, 1 an aligned load, 2 an aligned store, 3 any access.
    function automatic cpu_pkg::master_ex_t random_master(input int kind);
        cpu_pkg::master_ex_t m;
        cpu_pkg::aluop_t     ops [8];
        logic [319:0]        v;
        v   = random_bits();
        m   = v[$bits(cpu_pkg::master_ex_t)-1:0];
        ops = '{cpu_pkg::ALUOP_LB, cpu_pkg::ALUOP_LBU, cpu_pkg::ALUOP_LH, cpu_pkg::ALUOP_LHU,
                cpu_pkg::ALUOP_LW, cpu_pkg::ALUOP_SB, cpu_pkg::ALUOP_SH, cpu_pkg::ALUOP_SW};
        m.except = '0;
        if ($urandom_range(0, 15) == 0) begin
            m.except[cpu_pkg::EXC_SYS] = 1'b1;
        end
        m.mem_en = (kind != 0);
        if (kind != 0) begin
            case (kind)
                1: m.aluop = ops[3'($urandom_range(0, 4))];
                2: m.aluop = ops[3'($urandom_range(5, 7))];
                default: m.aluop = ops[3'($urandom_range(0, 7))];
            endcase
            m.mem_addr = {22'd0, 10'($urandom)}; // stays inside the 1 KiB RAM.
            m.memtoreg = !is_store_op(m.aluop);
            if (kind != 3 && op_size(m.aluop) == 4) begin
                m.mem_addr[1:0] = 2'b00;
            end else if (kind != 3 && op_size(m.aluop) == 2) begin
                m.mem_addr[0] = 1'b0;
            end
        end
        return m;
    endfunction

    function automatic cpu_pkg::slave_ex_t random_slave();
        cpu_pkg::slave_ex_t s;
        logic [319:0]       v;
        v        = random_bits();
        s        = v[$bits(cpu_pkg::slave_ex_t)-1:0];
        s.except = '0;
        if ($urandom_range(0, 15) == 0) begin
            s.except[cpu_pkg::EXC_SYS] = 1'b1;
        end
        return s;
    endfunction

    function automatic cpu_pkg::master_ex_t mem_op(input cpu_pkg::aluop_t op,
                                                   input cpu_pkg::word_t addr,
                                                   input cpu_pkg::word_t data);
        cpu_pkg::master_ex_t m;
        m           = '0;
        m.mem_en    = 1'b1;
        m.aluop     = op;
        m.mem_addr  = addr;
        m.rt_value  = data;
        m.reg_wen   = !is_store_op(op);
        m.memtoreg  = !is_store_op(op);
        m.reg_waddr = 5'd9;
        m.pc        = 32'h0040_0000 | addr;
        return m;
    endfunction

    function automatic cpu_pkg::word_t fill_word(input int idx);
        return (32'(idx) * 32'h0101_0101) ^ 32'h8c3e_5a17;
    endfunction

    task automatic write_model_store(input cpu_pkg::master_ex_t m);
        cpu_pkg::word_t w;
        int             sz;
        int             boff;
        sz = m.mem_en ? op_size(m.aluop) : 0;
        if (sz != 0 && is_store_op(m.aluop) && expected_master_except(m) == '0) begin
            boff = int'(m.mem_addr[1:0]);
            w    = mdl_mem[m.mem_addr[cpu_pkg::RAM_AW+1:2]];
            for (int i = 0; i < sz; i++) begin
                w[8*(boff+i) +: 8] = m.rt_value[8*i +: 8];
            end
            mdl_mem[m.mem_addr[cpu_pkg::RAM_AW+1:2]] = w;
        end
    endtask

    task automatic update_model(input cpu_pkg::master_ex_t em, input cpu_pkg::slave_ex_t es,
                                input logic st, input logic fl);
        write_model_store(mdl_master); // the store in M lands at this edge.
        if (fl) begin
            mdl_master = '0;
            mdl_slave  = '0;
        end else if (!st) begin
            mdl_master = em;
            if (em.except != '0) begin
                mdl_slave = '0;
            end else begin
                mdl_slave = es;
            end
        end
    endtask

    task automatic check_commit(input string name, input logic st, input logic fl);
        cpu_pkg::commit_t exp_m;
        cpu_pkg::commit_t exp_s;
        exp_m  = expected_master(mdl_master);
        exp_s  = expected_slave(mdl_slave, expected_master_except(mdl_master) != '0);
        checks += 2;
        assert (m_master_commit === exp_m) else begin
            errors++;
            $display("Fail %s master: expected %h, actual %h", name, exp_m, m_master_commit);
        end
        assert (m_slave_commit === exp_s) else begin
            errors++;
            $display("Fail %s slave: expected %h, actual %h", name, exp_s, m_slave_commit);
        end
        if (st && !fl) begin
            checks++;
            assert (m_master_commit === last_master && m_slave_commit === last_slave) else begin
                errors++;
                $display("Fail %s stall hold: expected %h %h, actual %h %h", name,
                         last_master, last_slave, m_master_commit, m_slave_commit);
            end
        end
        if (fl) begin
            checks++;
            assert (m_master_commit === '0 && m_slave_commit === '0) else begin
                errors++;
                $display("Fail %s flush: expected 0 0, actual %h %h", name,
                         m_master_commit, m_slave_commit);
            end
        end
        last_master = m_master_commit;
        last_slave  = m_slave_commit;
    endtask

    task automatic check_idle(input string name);
        checks++;
        assert (writes_off(m_master_commit) && writes_off(m_slave_commit)
                && m_master_commit.except == '0 && m_slave_commit.except == '0) else begin
            errors++;
            $display("%s: a write enable or exception is active without any bundle", name);
        end
    endtask

    task automatic run_cycle(input cpu_pkg::master_ex_t em, input cpu_pkg::slave_ex_t es,
                             input logic st, input logic fl, input string name);
        e_master = em;
        e_slave  = es;
        stall_m  = st;
        flush    = fl;
        @(posedge clk);
        update_model(em, es, st, fl);
        #1;
        check_commit(name, st, fl);
    endtask

    task automatic check_flag(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        cpu_pkg::master_ex_t em;
        cpu_pkg::slave_ex_t  es;
        void'($urandom(SEED));
        checks     = 0;
        errors     = 0;
        stall_m    = 1'b0;
        flush      = 1'b0;
        e_master   = '0;
        e_slave    = '0;
        mdl_master = '0;
        mdl_slave  = '0;
        foreach (mdl_mem[i]) begin
            mdl_mem[i] = '0;
        end

        @(posedge clk);
        #1;
        check_idle("during reset");
        wait (arst_n === 1'b1);
        check_idle("after reset");
        last_master = m_master_commit;
        last_slave  = m_slave_commit;
        run_cycle('0, '0, 1'b0, 1'b0, "idle after reset");

        for (int i = 0; i < 2**cpu_pkg::RAM_AW; i++) begin
            run_cycle(mem_op(cpu_pkg::ALUOP_SW, 32'(i) << 2, fill_word(i)), '0, 1'b0, 1'b0,
                      "fill");
        end

        // fill_word(5) has a negative top byte and top half.
        for (int off = 0; off < 4; off++) begin
            run_cycle(mem_op(cpu_pkg::ALUOP_LB, 32'h14 + 32'(off), '0), '0, 1'b0, 1'b0, "lb");
            run_cycle(mem_op(cpu_pkg::ALUOP_LBU, 32'h14 + 32'(off), '0), '0, 1'b0, 1'b0, "lbu");
        end
        for (int off = 0; off < 4; off += 2) begin
            run_cycle(mem_op(cpu_pkg::ALUOP_LH, 32'h14 + 32'(off), '0), '0, 1'b0, 1'b0, "lh");
            run_cycle(mem_op(cpu_pkg::ALUOP_LHU, 32'h14 + 32'(off), '0), '0, 1'b0, 1'b0, "lhu");
        end
        run_cycle(mem_op(cpu_pkg::ALUOP_LW, 32'h14, '0), '0, 1'b0, 1'b0, "lw");

        run_cycle(mem_op(cpu_pkg::ALUOP_SB, 32'h21, 32'h0000_00c4), '0, 1'b0, 1'b0, "sb");
        run_cycle(mem_op(cpu_pkg::ALUOP_SH, 32'h22, 32'h0000_7e81), '0, 1'b0, 1'b0, "sh");
        run_cycle(mem_op(cpu_pkg::ALUOP_LW, 32'h20, '0), '0, 1'b0, 1'b0, "lw after sb sh");
        run_cycle(mem_op(cpu_pkg::ALUOP_LW, 32'h24, '0), '0, 1'b0, 1'b0, "lw next word");

        es         = random_slave();
        es.except  = '0;
        es.reg_wen = 1'b1;
        es.cp0_wen = 1'b1;
        run_cycle(mem_op(cpu_pkg::ALUOP_LW, 32'h41, '0), es, 1'b0, 1'b0, "misaligned lw");
        check_flag(m_master_commit.except[cpu_pkg::EXC_ADEL] && !m_master_commit.reg_wen
                   && writes_off(m_slave_commit), "misaligned lw was not suppressed");
        run_cycle(mem_op(cpu_pkg::ALUOP_SW, 32'h46, 32'hdead_beef), es, 1'b0, 1'b0,
                  "misaligned sw");
        check_flag(m_master_commit.except[cpu_pkg::EXC_ADES] && writes_off(m_slave_commit),
                   "misaligned sw was not suppressed");
        run_cycle(mem_op(cpu_pkg::ALUOP_LH, 32'h43, '0), es, 1'b0, 1'b0, "misaligned lh");
        run_cycle(mem_op(cpu_pkg::ALUOP_SH, 32'h45, 32'h1234), es, 1'b0, 1'b0, "misaligned sh");
        run_cycle(mem_op(cpu_pkg::ALUOP_LW, 32'h44, '0), '0, 1'b0, 1'b0, "old data");
        checks++;
        assert (m_master_commit.reg_wdata === fill_word(17)) else begin
            errors++;
            $display("Fail old data: expected %h, actual %h", fill_word(17),
                     m_master_commit.reg_wdata);
        end

        run_cycle(mem_op(cpu_pkg::ALUOP_SW, 32'h80, 32'h0bad_f00d), '0, 1'b0, 1'b0, "sw");
        run_cycle(random_master(0), random_slave(), 1'b1, 1'b0, "stall on store");
        run_cycle(random_master(3), random_slave(), 1'b1, 1'b0, "stall on store");
        run_cycle(mem_op(cpu_pkg::ALUOP_LW, 32'h80, '0), '0, 1'b0, 1'b0, "lw after stall");
        run_cycle(random_master(0), random_slave(), 1'b0, 1'b0, "before stall");
        run_cycle(random_master(1), random_slave(), 1'b1, 1'b0, "stall");
        run_cycle(random_master(2), random_slave(), 1'b1, 1'b0, "stall");

        run_cycle(random_master(2), random_slave(), 1'b0, 1'b0, "before flush");
        run_cycle(random_master(1), random_slave(), 1'b0, 1'b1, "flush");
        run_cycle(random_master(0), random_slave(), 1'b1, 1'b1, "flush under stall");

        em                         = random_master(0);
        em.except                  = '0;
        em.except[cpu_pkg::EXC_SYS] = 1'b1;
        em.reg_wen                 = 1'b1;
        es                         = random_slave();
        es.reg_wen                 = 1'b1;
        run_cycle(em, es, 1'b0, 1'b0, "master exception");
        check_flag(!m_master_commit.reg_wen && m_master_commit.except[cpu_pkg::EXC_SYS]
                   && m_slave_commit === '0, "excepting master did not kill its pair");

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            em = random_master(int'($urandom_range(0, 3)));
            es = random_slave();
            run_cycle(em, es, $urandom_range(0, 15) == 0, $urandom_range(0, 31) == 0, "random");
        end
        run_cycle('0, '0, 1'b0, 1'b0, "drain");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period.
    end

    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* src.f */
hdl/cpu_pkg.sv
hdl/issue_flush_ctrl.sv
hdl/ex_mem.sv
hdl/mem_commit.sv
hdl/data_ram.sv
hdl/mem_stage.sv
sim/tb_clock.sv
sim/mem_stage_tb.sv
